/* rtl/sdram_params.svh */
/*
 * SDRAM controller parameters
 * Bus and pin widths, disk geometry fields and the mode register word
 */
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// ==================================================
// SDRAM pins
// ==================================================
`define SDRAM_DATA_W    16  // DQ width, also the bus word width
`define SDRAM_ADDR_W    13  // A12..A0
`define SDRAM_BANK_W    2   // BS1, BS0

// Auto precharge on read/write, precharge all on PRE
`define A10_BIT         10

// Mode register
// A9 = 1 burst read, single write
// A6..A4 = 010 CAS latency 2
// A3 = 0 sequential, A2..A0 = 000 burst length 1
`define MODE_REG_VALUE  13'h220

// ==================================================
// Disk image addressing
// ==================================================
`define MEM_ADDR_W      24  // Word address, bank + row + column
`define CYL_W           8   // Cylinder number
`define SECTOR_W        2   // Sector under the heads
`define WORD_OFFSET_W   9   // Words in one sector, lowest address bits

`endif

/* rtl/sdram_pkg.sv */
/*
 * SDRAM controller types
 * Word address layout, FSM states and the SDRAM command opcodes
 */
`include "sdram_params.svh"

package sdram_pkg;

    // Word address as seen by the SDRAM, bank in the top bits
    typedef struct packed {
        logic [`SDRAM_BANK_W-1:0]  bank;
        logic [`SDRAM_ADDR_W-1:0]  row;
        logic [`WORD_OFFSET_W-1:0] column;
    } mem_addr_t;

    // Controller FSM, init states first
    typedef enum logic [4:0] {
        init_nop,             // NOP with DQM high after reset
        init_precharge,       // Precharge all banks
        init_precharge_wait,
        init_load_mode,       // Mode register write
        dispatch,             // Pick read, write or refresh
        rd_activate,
        rd_nop,
        rd_autoprecharge,     // Read with A10 set
        rd_wait,
        rd_capture,
        wr_activate,
        wr_nop,
        wr_autoprecharge,     // Write with A10 set
        wr_wait,
        wr_after_wait,
        ref_issue,            // Auto refresh
        ref_wait1,
        ref_wait2
    } seq_state_e;

    // Bits are {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        cmd_nop           = 4'b1111,  // CS high, deselect
        cmd_activate      = 4'b0011,
        cmd_read          = 4'b0101,
        cmd_write         = 4'b0100,
        cmd_refresh       = 4'b0001,
        cmd_precharge_all = 4'b0010,
        cmd_load_mode     = 4'b0000
    } sdram_cmd_e;

endpackage

/* rtl/mem_req_if.sv */
/*
 * Memory request interface
 * Request levels and current word address out of the address unit,
 * done strobes back from the SDRAM sequencer
 */
`timescale 1ns/100ps

interface mem_req_if;
    import sdram_pkg::*;

    logic      read_req;    // Level, held until read_done
    logic      write_req;   // Level, held until write_done
    mem_addr_t cur_addr;    // Current word address
    logic      read_done;   // One cycle, in rd_capture
    logic      write_done;  // One cycle, in wr_after_wait

    modport addr_side (
        output read_req,
        output write_req,
        output cur_addr,
        input  read_done,
        input  write_done
    );

    modport seq_side (
        input  read_req,
        input  write_req,
        input  cur_addr,
        output read_done,
        output write_done
    );

endinterface

/* rtl/disk_address_unit.sv */
/*
 * Disk address unit
 * Word address register loaded from cylinder, head and sector,
 * plus the read and write request latches for the sequencer
 */
`timescale 1ns/100ps
`include "sdram_params.svh"

module disk_address_unit (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 load_address_busread,   // Sector load for a bus read
    input  logic                 load_address_buswrite,  // Sector load for a bus write
    input  logic                 dram_read_enbl,         // Read next word
    input  logic                 dram_write_enbl,        // Write current word
    input  logic                 dram_addr_incr,         // Skip a word without access
    input  logic                 dram_writeack,          // Write finished, step address
    input  logic [`SECTOR_W-1:0] sector_address,
    input  logic [`CYL_W-1:0]    cylinder_address,
    input  logic                 head_select,
    mem_req_if.addr_side         req
);
    import sdram_pkg::*;

    // Unused high address bits above the cylinder
    localparam int PAD_W = `MEM_ADDR_W - `CYL_W - 1 - `SECTOR_W - `WORD_OFFSET_W;

    logic      load_strobe;
    logic      incr_strobe;
    mem_addr_t load_addr;

    assign load_strobe = load_address_busread | load_address_buswrite;
    assign incr_strobe = dram_read_enbl | dram_addr_incr | dram_writeack;

    // Start of sector, word offset zero
    assign load_addr = {{PAD_W{1'b0}},
                        cylinder_address,
                        head_select,
                        sector_address,
                        {`WORD_OFFSET_W{1'b0}}};

    // ==================================================
    // Word address register
    // ==================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            req.cur_addr <= '0;
        end else if (load_strobe) begin
            req.cur_addr <= load_addr;  // Load wins over any increment
        end else if (incr_strobe) begin
            req.cur_addr <= mem_addr_t'(req.cur_addr + 1'b1);
        end
    end

    // ==================================================
    // Request latches
    // ==================================================
    // Set by a strobe, cleared by the done pulse unless a new strobe
    // lands in the same cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            req.read_req  <= 1'b0;
            req.write_req <= 1'b0;
        end else begin
            // Prefetch, the word at the new address is fetched right away
            req.read_req  <= load_address_busread | dram_read_enbl
                           | (req.read_req & ~req.read_done);
            req.write_req <= dram_write_enbl
                           | (req.write_req & ~req.write_done);
        end
    end

    // Bus side never loads and skips in the same cycle
    a_no_load_with_incr : assert property (
        @(posedge clock) disable iff (reset)
        load_strobe |-> !dram_addr_incr
    );

endmodule

/* rtl/sdram_sequencer.sv */
/*
 * SDRAM command sequencer
 * Power-up init, auto refresh when idle, single word read and write
 * with auto precharge; all SDRAM pins leave through registers
 */
`timescale 1ns/100ps
`include "sdram_params.svh"

module sdram_sequencer (
    input  logic                     clock,
    input  logic                     reset,
    mem_req_if.seq_side              req,
    input  logic [`SDRAM_DATA_W-1:0] writedata,       // Bus write word
    input  logic [`SDRAM_DATA_W-1:0] sdram_dq_in,     // From DQ receivers
    output logic [`SDRAM_DATA_W-1:0] dram_readdata,   // Word at the current address
    output logic                     dram_writeack,   // One cycle per finished write
    output logic [`SDRAM_DATA_W-1:0] sdram_dq_out,    // To DQ drivers
    output logic                     sdram_dq_enable, // DQ driver enable
    output logic [`SDRAM_ADDR_W-1:0] sdram_address,
    output logic [`SDRAM_BANK_W-1:0] sdram_bank,
    output logic                     sdram_cs_n,
    output logic                     sdram_ras_n,
    output logic                     sdram_cas_n,
    output logic                     sdram_we_n,
    output logic [1:0]               sdram_dqm        // {upper, lower} byte mask
);
    import sdram_pkg::*;

    seq_state_e               state;
    seq_state_e               next_state;
    sdram_cmd_e               cmd_q;          // Command on the pins
    sdram_cmd_e               next_cmd;
    logic [`SDRAM_ADDR_W-1:0] next_addr;
    logic [`SDRAM_BANK_W-1:0] next_bank;
    logic [`SDRAM_DATA_W-1:0] next_dq;
    logic                     next_dq_en;
    logic [1:0]               next_dqm;
    logic [`SDRAM_ADDR_W-1:0] col_with_ap;    // Column plus auto precharge bit
    logic                     capture_q;

    always_comb begin
        col_with_ap = '0;
        col_with_ap[`WORD_OFFSET_W-1:0] = req.cur_addr.column;
        col_with_ap[`A10_BIT] = 1'b1;
    end

    // ==================================================
    // Next state and next pin values
    // ==================================================
    always_comb begin
        next_state = state;
        next_cmd   = cmd_nop;           // Most states deselect
        next_addr  = '0;
        next_bank  = '0;
        next_dq    = '0;
        next_dq_en = 1'b0;
        next_dqm   = 2'b00;
        case (state)
            init_nop: begin
                next_state = init_precharge;
                next_dqm   = 2'b11;     // Masks held high until init runs
            end
            init_precharge: begin
                next_state = init_precharge_wait;
                next_cmd   = cmd_precharge_all;
                next_addr[`A10_BIT] = 1'b1;  // All banks
            end
            init_precharge_wait: next_state = init_load_mode;
            init_load_mode: begin
                next_state = dispatch;
                next_cmd   = cmd_load_mode;
                next_addr  = `MODE_REG_VALUE;  // CL2, BL1
            end
            dispatch: begin
                if (req.read_req) begin
                    next_state = rd_activate;
                end else if (req.write_req) begin
                    next_state = wr_activate;
                end else begin
                    next_state = ref_issue;  // Nothing pending so keep the array refreshed
                end
            end
            rd_activate, wr_activate: begin
                next_state = (state == rd_activate) ? rd_nop : wr_nop;
                next_cmd   = cmd_activate;
                next_bank  = req.cur_addr.bank;
                next_addr  = req.cur_addr.row;  // Open the row
            end
            rd_nop:  next_state = rd_autoprecharge;
            rd_autoprecharge: begin
                next_state = rd_wait;
                next_cmd   = cmd_read;
                next_bank  = req.cur_addr.bank;
                next_addr  = col_with_ap;
            end
            rd_wait:    next_state = rd_capture;   // CAS latency
            rd_capture: next_state = dispatch;
            wr_nop:     next_state = wr_autoprecharge;
            wr_autoprecharge: begin
                next_state = wr_wait;
                next_cmd   = cmd_write;
                next_bank  = req.cur_addr.bank;
                next_addr  = col_with_ap;
                next_dq    = writedata;
                next_dq_en = 1'b1;      // Data goes out with the command
            end
            wr_wait:       next_state = wr_after_wait;
            wr_after_wait: next_state = dispatch;
            ref_issue: begin
                next_state = ref_wait1;
                next_cmd   = cmd_refresh;
            end
            ref_wait1: next_state = ref_wait2;
            ref_wait2: next_state = dispatch;   // tRC covered
            default:   next_state = init_nop;
        endcase
    end

    // ==================================================
    // State and registered pins
    // ==================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            state           <= init_nop;
            cmd_q           <= cmd_nop;
            sdram_dq_enable <= 1'b0;
            sdram_dqm       <= 2'b11;
            capture_q       <= 1'b0;
            dram_readdata   <= '0;
            dram_writeack   <= 1'b0;
        end else begin
            state           <= next_state;
            cmd_q           <= next_cmd;
            sdram_dq_enable <= next_dq_en;
            sdram_dqm       <= next_dqm;
            capture_q       <= (state == rd_capture);
            if (capture_q) begin
                dram_readdata <= sdram_dq_in;   // DQ valid one cycle after rd_capture
            end
            dram_writeack   <= (state == wr_wait);
        end
    end

    // Address, bank and write data pins
    always_ff @(posedge clock) begin
        sdram_address <= next_addr;
        sdram_bank    <= next_bank;
        sdram_dq_out  <= next_dq;
    end

    assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd_q;

    // Done strobes back to the request latches
    assign req.read_done  = (state == rd_capture);
    assign req.write_done = (state == wr_after_wait);

    // DQ driven only with the write command of a pending write request
    a_dq_enable_write : assert property (
        @(posedge clock) disable iff (reset)
        sdram_dq_enable |-> ((cmd_q == cmd_write) && req.write_req) ##1 !sdram_dq_enable
    );

    a_state_legal : assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown(state) && (state inside {[init_nop:ref_wait2]})
    );

endmodule

/* rtl/sdram_ctrl_top.sv */
/*
 * Disk-pack emulator SDRAM controller
 * Connects the disk address unit and the SDRAM sequencer
 */
`timescale 1ns/100ps
`include "sdram_params.svh"

module sdram_ctrl_top (
    input  logic                     clock,
    input  logic                     reset,
    // Bus side
    input  logic                     load_address_busread,
    input  logic                     load_address_buswrite,
    input  logic                     dram_read_enbl,
    input  logic                     dram_write_enbl,
    input  logic                     dram_addr_incr,
    input  logic [`SDRAM_DATA_W-1:0] writedata,
    input  logic [`SECTOR_W-1:0]     sector_address,
    input  logic [`CYL_W-1:0]        cylinder_address,
    input  logic                     head_select,
    output logic                     dram_writeack,
    output logic [`SDRAM_DATA_W-1:0] dram_readdata,
    // SDRAM pins
    input  logic [`SDRAM_DATA_W-1:0] sdram_dq_in,
    output logic [`SDRAM_DATA_W-1:0] sdram_dq_out,
    output logic                     sdram_dq_enable,
    output logic [`SDRAM_ADDR_W-1:0] sdram_address,
    output logic [`SDRAM_BANK_W-1:0] sdram_bank,
    output logic                     sdram_cs_n,
    output logic                     sdram_ras_n,
    output logic                     sdram_cas_n,
    output logic                     sdram_we_n,
    output logic [1:0]               sdram_dqm
);

    mem_req_if req_bus ();  // Requests and current address

    disk_address_unit u_addr (
        .clock                 (clock),
        .reset                 (reset),
        .load_address_busread  (load_address_busread),
        .load_address_buswrite (load_address_buswrite),
        .dram_read_enbl        (dram_read_enbl),
        .dram_write_enbl       (dram_write_enbl),
        .dram_addr_incr        (dram_addr_incr),
        .dram_writeack         (dram_writeack),  // Steps the address after a write
        .sector_address        (sector_address),
        .cylinder_address      (cylinder_address),
        .head_select           (head_select),
        .req                   (req_bus.addr_side)
    );

    sdram_sequencer u_seq (
        .clock           (clock),
        .reset           (reset),
        .req             (req_bus.seq_side),
        .writedata       (writedata),
        .sdram_dq_in     (sdram_dq_in),
        .dram_readdata   (dram_readdata),
        .dram_writeack   (dram_writeack),
        .sdram_dq_out    (sdram_dq_out),
        .sdram_dq_enable (sdram_dq_enable),
        .sdram_address   (sdram_address),
        .sdram_bank      (sdram_bank),
        .sdram_cs_n      (sdram_cs_n),
        .sdram_ras_n     (sdram_ras_n),
        .sdram_cas_n     (sdram_cas_n),
        .sdram_we_n      (sdram_we_n),
        .sdram_dqm       (sdram_dqm)
    );

endmodule

/* verif/tb_clock_gen.sv */
/*
 * Testbench clock and reset source
 * 10 ns clock, synchronous reset held for a set number of cycles
 */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;  // 100 MHz
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;              // Released on a rising edge
    end

endmodule

/* verif/sdram_checker.sv */
/*
 * SDRAM controller checker
 * Decodes the SDRAM pins, tracks the expected word address and a
 * reference memory, and compares commands, write data and read data
 */
`timescale 1ns/100ps
`include "sdram_params.svh"

module sdram_checker (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     load_address_busread,
    input  logic                     load_address_buswrite,
    input  logic                     dram_read_enbl,
    input  logic                     dram_write_enbl,
    input  logic                     dram_addr_incr,
    input  logic [`SDRAM_DATA_W-1:0] writedata,
    input  logic [`SECTOR_W-1:0]     sector_address,
    input  logic [`CYL_W-1:0]        cylinder_address,
    input  logic                     head_select,
    input  logic                     dram_writeack,
    input  logic [`SDRAM_DATA_W-1:0] dram_readdata,
    input  logic [`SDRAM_DATA_W-1:0] sdram_dq_out,
    input  logic                     sdram_dq_enable,
    input  logic [`SDRAM_ADDR_W-1:0] sdram_address,
    input  logic [`SDRAM_BANK_W-1:0] sdram_bank,
    input  logic                     sdram_cs_n,
    input  logic                     sdram_ras_n,
    input  logic                     sdram_cas_n,
    input  logic                     sdram_we_n,
    input  logic [1:0]               sdram_dqm,
    input  logic                     check_strobe,    // Compare dram_readdata now
    input  logic                     check_use_file,  // Expected word from the input file
    input  logic [`SDRAM_DATA_W-1:0] check_value,
    input  logic                     end_of_test,
    output int                       error_count,
    output int                       check_count
);
    import sdram_pkg::*;

    logic [3:0]  pins;
    logic [23:0] model_addr;                 // {bank, row, column}
    logic [15:0] ref_mem [logic [23:0]];     // Expected memory contents
    logic [15:0] pending_data;               // Bus word of the last write strobe
    sdram_cmd_e  last_cmd;                   // Last command other than NOP
    int          cycle;
    int          init_cycle;
    int          last_ref_cycle;
    int          n_wr_strobe;
    int          n_wr_cmd;
    int          n_ack;
    bit          final_done;

    assign pins = {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n};

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("error: %s at %0t", what, $time);
    endtask

    // ==================================================
    // Pin and bus monitor
    // ==================================================
    always @(posedge clock) begin : monitor
        logic [12:0] exp_col;
        logic [15:0] exp_word;
        exp_col = '0;
        exp_col[8:0] = model_addr[8:0];
        exp_col[`A10_BIT] = 1'b1;           // Auto precharge
        if (reset) begin
            model_addr     = '0;
            last_cmd       = cmd_nop;
            cycle          = 0;
            init_cycle     = 0;
            last_ref_cycle = 0;
            n_wr_strobe    = 0;
            n_wr_cmd       = 0;
            n_ack          = 0;
            error_count    = 0;
            check_count    = 0;
            final_done     = 1'b0;
        end else begin
            cycle++;
            // Power-up sequence with one command per cycle
            case (init_cycle)
                1: begin
                    if (pins != cmd_nop)
                        report_mismatch("init command 1", 32'(pins), 32'(cmd_nop));
                    if (sdram_dqm != 2'b11) report_mismatch("sdram_dqm", 32'(sdram_dqm), 32'h3);
                end
                2: begin
                    if (pins != cmd_precharge_all)
                        report_mismatch("init command 2", 32'(pins), 32'(cmd_precharge_all));
                    if (!sdram_address[`A10_BIT]) report_error("precharge all without A10");
                end
                3: begin
                    if (pins != cmd_nop)
                        report_mismatch("init command 3", 32'(pins), 32'(cmd_nop));
                end
                4: begin
                    if (pins != cmd_load_mode)
                        report_mismatch("init command 4", 32'(pins), 32'(cmd_load_mode));
                    if (sdram_address != `MODE_REG_VALUE)
                        report_mismatch("sdram_address", 32'(sdram_address), 32'h220);
                end
                default: ;
            endcase
            if (init_cycle < 5) init_cycle++;

            if (sdram_dq_enable && pins != cmd_write)
                report_error("DQ driven in a cycle without a write command");

            case (pins)
                cmd_refresh: begin
                    // Back to back refreshes come from an idle dispatch loop
                    if (last_cmd == cmd_refresh && cycle - last_ref_cycle != 4)
                        report_mismatch("refresh gap", 32'(cycle - last_ref_cycle), 32'd4);
                    last_ref_cycle = cycle;
                end
                cmd_activate: begin
                    if (sdram_bank != model_addr[23:22])
                        report_mismatch("sdram_bank", 32'(sdram_bank), 32'(model_addr[23:22]));
                    if (sdram_address != model_addr[21:9])
                        report_mismatch("sdram_address", 32'(sdram_address),
                                        32'(model_addr[21:9]));
                end
                cmd_read, cmd_write: begin
                    if (sdram_bank != model_addr[23:22])
                        report_mismatch("sdram_bank", 32'(sdram_bank), 32'(model_addr[23:22]));
                    if (sdram_address != exp_col)
                        report_mismatch("sdram_address", 32'(sdram_address), 32'(exp_col));
                    if (sdram_dqm != 2'b00)
                        report_mismatch("sdram_dqm", 32'(sdram_dqm), 32'h0);  // No byte masking
                    if (pins == cmd_write) begin
                        n_wr_cmd++;
                        if (sdram_dq_out != pending_data)
                            report_mismatch("sdram_dq_out", 32'(sdram_dq_out),
                                            32'(pending_data));
                        ref_mem[model_addr] = pending_data;
                    end
                end
                default: ;
            endcase
            if (pins != cmd_nop) last_cmd = sdram_cmd_e'(pins);

            // Read data holds the prefetched word at the current address
            if (check_strobe) begin
                check_count++;
                exp_word = ref_mem.exists(model_addr) ? ref_mem[model_addr] : 16'h0000;
                if (check_use_file) exp_word = check_value;
                if (dram_readdata != exp_word)
                    report_mismatch("dram_readdata", 32'(dram_readdata), 32'(exp_word));
            end

            // Expected address with load before increment
            if (load_address_busread || load_address_buswrite) begin
                model_addr = {4'b0000, cylinder_address, head_select, sector_address, 9'h000};
            end else if (dram_read_enbl || dram_addr_incr || dram_writeack) begin
                model_addr = model_addr + 24'd1;
            end
            if (dram_write_enbl) begin
                pending_data = writedata;
                n_wr_strobe++;
            end
            if (dram_writeack) n_ack++;

            if (end_of_test && !final_done) begin
                final_done = 1'b1;
                if (n_wr_cmd != n_wr_strobe)
                    report_error("write command count differs from write strobes");
                if (n_ack != n_wr_strobe)
                    report_error("writeack count differs from write strobes");
            end
        end
    end

endmodule

/* verif/sdram_ctrl_tb.sv */
/*
 * SDRAM controller testbench
 * Replays the operation records of the input file on the bus side,
 * answers SDRAM reads from a small DQ model and guards the run time
 */
`timescale 1ns/100ps
`include "sdram_params.svh"

module sdram_ctrl_tb;
    import sdram_pkg::*;

    // One line of the input file, all fields hex
    typedef struct packed {
        logic [31:0] op;
        logic [31:0] cyl;
        logic [31:0] head;
        logic [31:0] sec;
        logic [31:0] data;
        logic [31:0] chk;
        logic [31:0] exp;
    } record_t;

    logic        clock;
    logic        reset;
    logic        load_address_busread;
    logic        load_address_buswrite;
    logic        dram_read_enbl;
    logic        dram_write_enbl;
    logic        dram_addr_incr;
    logic [15:0] writedata;
    logic [1:0]  sector_address;
    logic [7:0]  cylinder_address;
    logic        head_select;
    logic        dram_writeack;
    logic [15:0] dram_readdata;
    logic [15:0] sdram_dq_in = '0;
    logic [15:0] sdram_dq_out;
    logic        sdram_dq_enable;
    logic [12:0] sdram_address;
    logic [1:0]  sdram_bank;
    logic        sdram_cs_n;
    logic        sdram_ras_n;
    logic        sdram_cas_n;
    logic        sdram_we_n;
    logic [1:0]  sdram_dqm;
    logic        check_strobe;
    logic        check_use_file;
    logic [15:0] check_value;
    logic        end_of_test;
    int          error_count;
    int          check_count;

    record_t     records[$];
    bit          records_loaded = 1'b0;
    int          stim_errors = 0;
    logic [31:0] lfsr_state;
    logic [12:0] open_row [4];                // Row opened per bank
    logic [15:0] dq_mem [logic [23:0]];       // SDRAM array model

    tb_clock_gen #(.RESET_CYCLES(16)) u_clock (.clock(clock), .reset(reset));
    sdram_ctrl_top DUT (.*);
    sdram_checker u_checker (.*);

    // Galois LFSR, one step per bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_word(output logic [15:0] w);
        for (int i = 0; i < 16; i++) begin
            w = {w[14:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // ==================================================
    // DQ model, answers read commands with the stored word
    // ==================================================
    always @(posedge clock) begin : dq_responder
        logic [23:0] key;
        key = {sdram_bank, open_row[sdram_bank], sdram_address[8:0]};
        case ({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n})
            cmd_activate: open_row[sdram_bank] <= sdram_address;
            cmd_write:    dq_mem[key] = sdram_dq_out;
            cmd_read:     sdram_dq_in <= dq_mem.exists(key) ? dq_mem[key] : 16'h0000;
            default: ;
        endcase
    end

    task automatic load_records();
        int      fd;
        int      n;
        string   line;
        record_t r;
        fd = $fopen("verif/sdram_input.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open verif/sdram_input.txt");
            stim_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != 8'h23) begin   // Skip comment lines
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                            r.op, r.cyl, r.head, r.sec, r.data, r.chk, r.exp);
                if (n == 7) records.push_back(r);
            end
        end
        $fclose(fd);
    endtask

    // One-cycle strobe, 1 load write, 2 load read, 3 read next, 4 incr, 5 write
    task automatic strobe(input int which);
        @(posedge clock);
        case (which)
            1: load_address_buswrite <= 1'b1;
            2: load_address_busread  <= 1'b1;
            3: dram_read_enbl        <= 1'b1;
            4: dram_addr_incr        <= 1'b1;
            default: dram_write_enbl <= 1'b1;
        endcase
        @(posedge clock);
        load_address_buswrite <= 1'b0;
        load_address_busread  <= 1'b0;
        dram_read_enbl        <= 1'b0;
        dram_addr_incr        <= 1'b0;
        dram_write_enbl       <= 1'b0;
    endtask

    task automatic run_record(input record_t r);
        logic [15:0] w;
        bit          got_ack;
        if (r.op == 32'd1 || r.op == 32'd2) begin
            cylinder_address <= r.cyl[7:0];
            head_select      <= r.head[0];
            sector_address   <= r.sec[1:0];
        end
        case (r.op)
            32'd0: repeat (r.data) @(posedge clock);   // Idle
            32'd1, 32'd4: strobe(int'(r.op));
            32'd2, 32'd3: begin
                strobe(int'(r.op));
                repeat (12) @(posedge clock);         // Worst case read latency
                if (r.chk != 32'd0) begin
                    check_strobe   <= 1'b1;
                    check_use_file <= (r.chk == 32'd1);
                    check_value    <= r.exp[15:0];
                    @(posedge clock);
                    check_strobe   <= 1'b0;
                end
            end
            32'd5, 32'd6: begin
                w = r.data[15:0];
                if (r.op == 32'd6) random_word(w);
                writedata <= w;                       // Held until the ack
                strobe(5);
                got_ack = 1'b0;
                for (int i = 0; i < 16 && !got_ack; i++) begin
                    @(posedge clock);
                    got_ack = dram_writeack;
                end
                if (!got_ack) begin
                    stim_errors++;
                    $display("error: no write acknowledge within 16 cycles at %0t", $time);
                end
            end
            default: begin
                stim_errors++;
                $display("error: unknown opcode %h in the input file", r.op);
            end
        endcase
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin : stimulus
        load_address_busread  = 1'b0;
        load_address_buswrite = 1'b0;
        dram_read_enbl        = 1'b0;
        dram_write_enbl       = 1'b0;
        dram_addr_incr        = 1'b0;
        writedata             = '0;
        sector_address        = '0;
        cylinder_address      = '0;
        head_select           = 1'b0;
        check_strobe          = 1'b0;
        check_use_file        = 1'b0;
        check_value           = '0;
        end_of_test           = 1'b0;
        lfsr_state            = 32'hca20;
        load_records();
        if (records.size() == 0) begin
            stim_errors++;
            $display("error: no operation records were read");
        end
        records_loaded = 1'b1;
        @(negedge reset);
        repeat (8) @(posedge clock);                  // Init sequence done
        foreach (records[i]) run_record(records[i]);
        repeat (4) @(posedge clock);
        end_of_test <= 1'b1;
        repeat (2) @(posedge clock);
        $display("read checks %0d, checker errors %0d, stimulus errors %0d",
                 check_count, error_count, stim_errors);
        if (error_count == 0 && stim_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Run time limit from the record count
    initial begin : watchdog
        wait (records_loaded);
        repeat (records.size() * 20 + 200) @(posedge clock);
        $display("error: run did not finish within %0d cycles", records.size() * 20 + 200);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* verif/sdram_input.txt */
# op cyl head sec data chk exp, all hex
# op 0 idle data cycles, 1 load write, 2 load read, 3 read next, 4 incr, 5 write, 6 random write
0 00 0 0 0000001e 0 0000
1 05 1 2 00000000 0 0000
5 05 1 2 00001234 0 0000
5 05 1 2 0000abcd 0 0000
5 05 1 2 0000beef 0 0000
6 05 1 2 00000000 0 0000
6 05 1 2 00000000 0 0000
4 05 1 2 00000000 0 0000
4 05 1 2 00000000 0 0000
5 05 1 2 00005a5a 0 0000
2 05 1 2 00000000 1 1234
3 05 1 2 00000000 1 abcd
3 05 1 2 00000000 1 beef
3 05 1 2 00000000 2 0000
3 05 1 2 00000000 2 0000
3 05 1 2 00000000 1 0000
3 05 1 2 00000000 1 0000
3 05 1 2 00000000 1 5a5a
3 05 1 2 00000000 1 0000
1 a3 0 3 00000000 0 0000
6 a3 0 3 00000000 0 0000
5 a3 0 3 00007777 0 0000
2 a3 0 3 00000000 2 0000
3 a3 0 3 00000000 1 7777
3 a3 0 3 00000000 1 0000
2 10 1 0 00000000 1 0000
0 00 0 0 00000014 0 0000

/* files.f */
+incdir+rtl
rtl/sdram_pkg.sv
rtl/mem_req_if.sv
rtl/disk_address_unit.sv
rtl/sdram_sequencer.sv
rtl/sdram_ctrl_top.sv
verif/tb_clock_gen.sv
verif/sdram_checker.sv
verif/sdram_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SDRAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -f files.f \
    --top-module sdram_ctrl_tb --Mdir obj_dir -o sdram_sim > build.log 2>&1 \
    && ./obj_dir/sdram_sim > sim.log 2>&1 \
    || { echo "Build or run error, see build.log and sim.log"; exit 1; }

grep -q "Testbench failed" sim.log \
    && { echo "Simulation FAILED, see sim.log"; exit 1; } \
    || { echo "Simulation ok"; exit 0; }
